/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := csr_trap_unit_tb
FILELIST := csr_trap_unit.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass" && exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* csr_trap_unit.f */
+incdir+tests
src/csr_pkg.sv
src/machine_timer.sv
src/trap_arbiter.sv
src/csr_file.sv
src/csr_trap_unit.sv
tests/csr_trap_unit_tb.sv

/* src/csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_file
  import csr_pkg::*;
(
  input  logic        clock,
  input  logic        reset,

  input  logic        csr_instr,
  input  csr_addr_t   csr_addr,
  input  xlen_t       csr_src,
  input  logic        mret_instr,
  input  xlen_t       pc,

  input  trap_grant_t grant,
  input  logic        timer_int,
  input  count_t      cycle_count,
  input  logic        soft_int,
  input  logic        ext_int,

  output xlen_t       csr_rdata,
  output logic        trap_taken,
  output xlen_t       mtvec,
  output xlen_t       mepc,
  output xlen_t       mie_bits,
  output logic        global_ie,
  output csr_wr_t     tmr_wr
);

  typedef enum logic [3:0] {
    SEL_MSTATUS,
    SEL_MIE,
    SEL_MTVEC,
    SEL_MEPC,
    SEL_MCAUSE,
    SEL_MIP,
    SEL_CYCLE,
    SEL_CYCLEH,
    SEL_TIMECMP,
    SEL_TIMECMPH,
    SEL_NONE
  } csr_sel_e;

  csr_sel_e csr_sel;
  xlen_t    mstatus;
  xlen_t    mie;
  cause_t   mcause;
  xlen_t    mip;
  xlen_t    rd_value;
  logic     csr_access;

  // ====================================================================
  // address decode and read mux
  // ====================================================================

  always_comb begin
    case (csr_addr)
      CSR_MSTATUS:   csr_sel = SEL_MSTATUS;
      CSR_MIE:       csr_sel = SEL_MIE;
      CSR_MTVEC:     csr_sel = SEL_MTVEC;
      CSR_MEPC:      csr_sel = SEL_MEPC;
      CSR_MCAUSE:    csr_sel = SEL_MCAUSE;
      CSR_MIP:       csr_sel = SEL_MIP;
      CSR_CYCLE:     csr_sel = SEL_CYCLE;
      CSR_CYCLEH:    csr_sel = SEL_CYCLEH;
      CSR_MTIMECMP:  csr_sel = SEL_TIMECMP;
      CSR_MTIMECMPH: csr_sel = SEL_TIMECMPH;
      default:       csr_sel = SEL_NONE;
    endcase
  end

  // mip mirrors the live interrupt lines.
  always_comb begin
    mip          = '0;
    mip[BIT_MSI] = soft_int;
    mip[BIT_MTI] = timer_int;
    mip[BIT_MEI] = ext_int;
  end

  // compare halves live in the timer and read back as zero.
  always_comb begin
    case (csr_sel)
      SEL_MSTATUS: rd_value = mstatus;
      SEL_MIE:     rd_value = mie;
      SEL_MTVEC:   rd_value = mtvec;
      SEL_MEPC:    rd_value = mepc;
      SEL_MCAUSE:  rd_value = mcause;
      SEL_MIP:     rd_value = mip;
      SEL_CYCLE:   rd_value = cycle_count[31:0];
      SEL_CYCLEH:  rd_value = cycle_count[63:32];
      default:     rd_value = '0;
    endcase
  end

  // ====================================================================
  // timer write path
  // ====================================================================

  assign csr_access = csr_instr & ~grant.take;  // trap drops the access.

  always_comb begin
    tmr_wr.en   = csr_access & ((csr_sel == SEL_TIMECMP) | (csr_sel == SEL_TIMECMPH));
    tmr_wr.addr = csr_addr;
    tmr_wr.data = csr_src;
  end

  // ====================================================================
  // state update
  // ====================================================================

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mstatus    <= '0;
      mie        <= '0;
      mtvec      <= '0;
      mepc       <= '0;
      mcause     <= '0;
      csr_rdata  <= '0;
      trap_taken <= 1'b0;
    end else begin
      trap_taken <= grant.take;
      if (grant.take) begin
        mepc              <= pc;
        mcause            <= grant.cause;
        mstatus[BIT_MPIE] <= mstatus[BIT_MIE];
        mstatus[BIT_MIE]  <= 1'b0;
      end else if (csr_instr) begin
        csr_rdata <= rd_value;  // old value out, source in.
        case (csr_sel)
          SEL_MSTATUS: mstatus <= csr_src;
          SEL_MIE:     mie     <= csr_src;
          SEL_MTVEC:   mtvec   <= csr_src;
          SEL_MEPC:    mepc    <= csr_src;
          SEL_MCAUSE:  mcause  <= csr_src;
          default: ;  // mip, cycle and unknown are read-only.
        endcase
      end else if (mret_instr) begin
        mstatus[BIT_MIE]  <= mstatus[BIT_MPIE];
        mstatus[BIT_MPIE] <= 1'b1;
      end
    end
  end

  assign mie_bits  = mie;
  assign global_ie = mstatus[BIT_MIE];

  // after a trap MIE is clear, so only an exception may trap again next cycle.
  property p_no_back_to_back_int;
    @(posedge clock) disable iff (reset)
      (trap_taken && !mstatus[BIT_MIE] && !(grant.take && !grant.cause[CAUSE_INT_BIT]))
        |=> !trap_taken;
  endproperty

  a_no_back_to_back_int: assert property (p_no_back_to_back_int)
    else $error("csr_file: interrupt taken with MIE clear, mcause %h", mcause);

endmodule

`default_nettype wire

/* src/csr_pkg.sv */
`default_nettype none

package csr_pkg;

  // ====================================================================
  // widths
  // ====================================================================

  typedef logic [31:0] xlen_t;      // csr data and pc values.
  typedef logic [11:0] csr_addr_t;  // csr address field.
  typedef logic [31:0] cause_t;     // mcause value, bit 31 flags an interrupt.
  typedef logic [63:0] count_t;     // cycle counter and compare width.

  // ====================================================================
  // csr addresses
  // ====================================================================

  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MIE       = 12'h304;
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MIP       = 12'h344;
  localparam csr_addr_t CSR_MTIMECMP  = 12'h7C0;  // custom, low half.
  localparam csr_addr_t CSR_MTIMECMPH = 12'h7C1;  // custom, high half.
  localparam csr_addr_t CSR_CYCLE     = 12'hC00;
  localparam csr_addr_t CSR_CYCLEH    = 12'hC80;

  // mstatus bits.
  localparam int BIT_MIE  = 3;
  localparam int BIT_MPIE = 7;

  // mie and mip bits.
  localparam int BIT_MSI = 3;
  localparam int BIT_MTI = 7;
  localparam int BIT_MEI = 11;

  localparam int CAUSE_INT_BIT = 31;

  // ====================================================================
  // cause codes
  // ====================================================================

  localparam cause_t CAUSE_M_SOFT_INT  = 32'h8000_0003;
  localparam cause_t CAUSE_M_TIMER_INT = 32'h8000_0007;
  localparam cause_t CAUSE_M_EXT_INT   = 32'h8000_000B;

  localparam cause_t CAUSE_ILLEGAL_INSTR = 32'd2;
  localparam cause_t CAUSE_BREAKPOINT    = 32'd3;
  localparam cause_t CAUSE_LOAD_ACCESS   = 32'd5;
  localparam cause_t CAUSE_ECALL_M       = 32'd11;

  // ====================================================================
  // shared bundles
  // ====================================================================

  // trap sources, all levels.
  typedef struct packed {
    logic illegal_instr;
    logic env_call;
    logic load_access;
    logic break_point;
    logic soft_int;
    logic ext_int;
  } trap_req_t;

  // winning trap for this cycle.
  typedef struct packed {
    logic   take;
    cause_t cause;
  } trap_grant_t;

  // csr write forwarded to a block outside the csr file.
  typedef struct packed {
    logic      en;
    csr_addr_t addr;
    xlen_t     data;
  } csr_wr_t;

endpackage

`default_nettype wire

/* src/csr_trap_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_trap_unit
  import csr_pkg::*;
(
  input  logic      clock,
  input  logic      reset,

  input  logic      csr_instr,
  input  csr_addr_t csr_addr,
  input  xlen_t     csr_src,
  input  logic      mret_instr,
  input  trap_req_t trap_req,
  input  xlen_t     pc,

  output xlen_t     csr_rdata,
  output logic      trap_taken,
  output xlen_t     mtvec,
  output xlen_t     mepc
);

  count_t      cycle_count;
  logic        timer_int;
  csr_wr_t     tmr_wr;
  xlen_t       mie_bits;
  logic        global_ie;
  trap_grant_t grant;

  machine_timer machine_timer_i (
    .clock       (clock),
    .reset       (reset),
    .tmr_wr      (tmr_wr),
    .cycle_count (cycle_count),
    .timer_int   (timer_int)
  );

  trap_arbiter trap_arbiter_i (
    .trap_req  (trap_req),
    .timer_int (timer_int),
    .mie_bits  (mie_bits),
    .global_ie (global_ie),
    .grant     (grant)
  );

  csr_file csr_file_i (
    .clock       (clock),
    .reset       (reset),
    .csr_instr   (csr_instr),
    .csr_addr    (csr_addr),
    .csr_src     (csr_src),
    .mret_instr  (mret_instr),
    .pc          (pc),
    .grant       (grant),
    .timer_int   (timer_int),
    .cycle_count (cycle_count),
    .soft_int    (trap_req.soft_int),
    .ext_int     (trap_req.ext_int),
    .csr_rdata   (csr_rdata),
    .trap_taken  (trap_taken),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .mie_bits    (mie_bits),
    .global_ie   (global_ie),
    .tmr_wr      (tmr_wr)
  );

endmodule

`default_nettype wire

/* src/machine_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module machine_timer
  import csr_pkg::*;
(
  input  logic    clock,
  input  logic    reset,

  input  csr_wr_t tmr_wr,

  output count_t  cycle_count,
  output logic    timer_int
);

  count_t compare;

  // ====================================================================
  // free-running counter
  // ====================================================================

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      cycle_count <= '0;
    end else begin
      cycle_count <= cycle_count + count_t'(1);
    end
  end

  // ====================================================================
  // compare register
  // ====================================================================

  // all ones keeps the timer quiet until software arms it.
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      compare <= '1;
    end else if (tmr_wr.en) begin
      case (tmr_wr.addr)
        CSR_MTIMECMP:  compare[31:0]  <= tmr_wr.data;  // low half.
        CSR_MTIMECMPH: compare[63:32] <= tmr_wr.data;  // high half.
        default: ;
      endcase
    end
  end

  assign timer_int = (cycle_count >= compare);  // level, held until compare moves.

  // the counter must advance on every clock out of reset.
  property p_count_advances;
    @(posedge clock) disable iff (reset)
      !$past(reset) |-> cycle_count != $past(cycle_count);
  endproperty

  a_count_advances: assert property (p_count_advances)
    else $error("machine_timer: cycle_count stalled at %h", cycle_count);

endmodule

`default_nettype wire

/* src/trap_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module trap_arbiter
  import csr_pkg::*;
(
  input  trap_req_t   trap_req,
  input  logic        timer_int,
  input  xlen_t       mie_bits,
  input  logic        global_ie,

  output trap_grant_t grant
);

  logic ext_ok;
  logic soft_ok;
  logic timer_ok;
  logic any_int;
  logic any_exc;

  // ====================================================================
  // qualify the sources
  // ====================================================================

  // interrupts need the global enable and their own mie bit.
  always_comb begin
    ext_ok   = global_ie & mie_bits[BIT_MEI] & trap_req.ext_int;
    soft_ok  = global_ie & mie_bits[BIT_MSI] & trap_req.soft_int;
    timer_ok = global_ie & mie_bits[BIT_MTI] & timer_int;
    any_int  = ext_ok | soft_ok | timer_ok;
  end

  // exceptions are synchronous to the instruction and never masked.
  always_comb begin
    any_exc = trap_req.break_point
            | trap_req.load_access
            | trap_req.illegal_instr
            | trap_req.env_call;
  end

  // ====================================================================
  // fixed priority
  // ====================================================================

  always_comb begin
    grant.take  = any_int | any_exc;
    grant.cause = '0;

    if (ext_ok) begin
      grant.cause = CAUSE_M_EXT_INT;
    end else if (soft_ok) begin
      grant.cause = CAUSE_M_SOFT_INT;
    end else if (timer_ok) begin
      grant.cause = CAUSE_M_TIMER_INT;
    end else if (trap_req.break_point) begin
      grant.cause = CAUSE_BREAKPOINT;
    end else if (trap_req.load_access) begin
      grant.cause = CAUSE_LOAD_ACCESS;
    end else if (trap_req.illegal_instr) begin
      grant.cause = CAUSE_ILLEGAL_INSTR;
    end else if (trap_req.env_call) begin
      grant.cause = CAUSE_ECALL_M;
    end
  end

  // an exception must always produce a take with an exception cause,
  // unless an enabled interrupt outranks it.
  always_comb begin
    if (any_exc) begin
      a_exc_taken: assert (grant.take && (any_int || !grant.cause[CAUSE_INT_BIT]))
        else $error("trap_arbiter: exception pending but no exception grant");
    end
  end

endmodule

`default_nettype wire

/* tests/csr_model.svh */
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// ======================================================================
// reference model of the machine csrs
// ======================================================================

xlen_t  m_mstatus;
xlen_t  m_mie;
xlen_t  m_mtvec;
xlen_t  m_mepc;
cause_t m_mcause;
count_t m_compare;
count_t m_cycle;  // own count, zero at reset release.
xlen_t  m_rdata;
logic   m_trap;   // trap_taken expected after the last edge.

function automatic void reset_model();
  m_mstatus = '0;
  m_mie     = '0;
  m_mtvec   = '0;
  m_mepc    = '0;
  m_mcause  = '0;
  m_compare = '1;
  m_cycle   = '0;
  m_rdata   = '0;
  m_trap    = 1'b0;
endfunction

// cause of the trap taken at this edge, zero when nothing is taken.
function automatic cause_t expected_cause(trap_req_t rq);
  logic on;
  logic tmr;
  on  = m_mstatus[3];
  tmr = (m_cycle >= m_compare);
  return (on && m_mie[11] && rq.ext_int)  ? 32'h8000_000b :
         (on && m_mie[3]  && rq.soft_int) ? 32'h8000_0003 :
         (on && m_mie[7]  && tmr)         ? 32'h8000_0007 :
         rq.break_point                   ? 32'd3 :
         rq.load_access                   ? 32'd5 :
         rq.illegal_instr                 ? 32'd2 :
         rq.env_call                      ? 32'd11 : 32'd0;
endfunction

function automatic xlen_t expected_read(csr_addr_t addr, trap_req_t rq);
  xlen_t v;
  v = '0;
  case (addr)
    CSR_MSTATUS: v = m_mstatus;
    CSR_MIE:     v = m_mie;
    CSR_MTVEC:   v = m_mtvec;
    CSR_MEPC:    v = m_mepc;
    CSR_MCAUSE:  v = m_mcause;
    CSR_MIP:     v = {20'd0, rq.ext_int, 3'd0, m_cycle >= m_compare, 3'd0, rq.soft_int, 3'd0};
    CSR_CYCLE:   v = m_cycle[31:0];
    CSR_CYCLEH:  v = m_cycle[63:32];
    default:     v = '0;  // unknown and compare halves.
  endcase
  return v;
endfunction

// one clock edge with the inputs that were held before it.
function automatic void step_model(logic ci, csr_addr_t addr, xlen_t src, logic mr,
                                   trap_req_t rq, xlen_t p);
  cause_t c;
  c      = expected_cause(rq);
  m_trap = (c != '0);
  if (m_trap) begin
    m_mepc       = p;
    m_mcause     = c;
    m_mstatus[7] = m_mstatus[3];
    m_mstatus[3] = 1'b0;
  end else if (ci) begin
    m_rdata = expected_read(addr, rq);
    case (addr)
      CSR_MSTATUS:   m_mstatus = src;
      CSR_MIE:       m_mie = src;
      CSR_MTVEC:     m_mtvec = src;
      CSR_MEPC:      m_mepc = src;
      CSR_MCAUSE:    m_mcause = src;
      CSR_MTIMECMP:  m_compare[31:0] = src;
      CSR_MTIMECMPH: m_compare[63:32] = src;
      default: ;
    endcase
  end else if (mr) begin
    m_mstatus[3] = m_mstatus[7];
    m_mstatus[7] = 1'b1;
  end
  m_cycle = m_cycle + 64'd1;
endfunction

`endif

/* tests/csr_trap_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_trap_unit_tb
  import csr_pkg::*;
();

  logic      clock;
  logic      reset;
  logic      csr_instr;
  csr_addr_t csr_addr;
  xlen_t     csr_src;
  logic      mret_instr;
  trap_req_t trap_req;
  xlen_t     pc;
  xlen_t     csr_rdata;
  logic      trap_taken;
  xlen_t     mtvec;
  xlen_t     mepc;

  logic [31:0] seed;
  trap_req_t   held_req;  // interrupt levels kept through idle cycles.
  csr_addr_t   addr_list [12];
  int          n_errors;

  `include "csr_model.svh"

  csr_trap_unit csr_trap_unit_i (
    .clock      (clock),
    .reset      (reset),
    .csr_instr  (csr_instr),
    .csr_addr   (csr_addr),
    .csr_src    (csr_src),
    .mret_instr (mret_instr),
    .trap_req   (trap_req),
    .pc         (pc),
    .csr_rdata  (csr_rdata),
    .trap_taken (trap_taken),
    .mtvec      (mtvec),
    .mepc       (mepc)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // ======================================================================
  // checks
  // ======================================================================

  task automatic stop_on_error();
    n_errors++;
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_word(string name, xlen_t got, xlen_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_cause(string name, cause_t got, cause_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  // ======================================================================
  // stimulus
  // ======================================================================

  // model the edge, drive the next inputs, compare at the falling edge.
  task automatic tick(logic ci, csr_addr_t addr, xlen_t src, logic mr, trap_req_t rq);
    logic read_cause;
    @(posedge clock);
    read_cause = csr_instr && (csr_addr == CSR_MCAUSE);
    step_model(csr_instr, csr_addr, csr_src, mret_instr, trap_req, pc);
    csr_instr  <= ci;
    csr_addr   <= addr;
    csr_src    <= src;
    mret_instr <= mr;
    trap_req   <= rq;
    pc         <= lcg_next() & 32'hffff_fffc;
    @(negedge clock);
    check_flag("trap_taken", trap_taken, m_trap);
    if (read_cause && !m_trap) begin
      check_cause("csr_rdata (mcause)", csr_rdata, m_rdata);
    end else begin
      check_word("csr_rdata", csr_rdata, m_rdata);
    end
    check_word("mtvec", mtvec, m_mtvec);
    check_word("mepc", mepc, m_mepc);
  endtask

  task automatic idle(int n);
    repeat (n) tick(1'b0, '0, '0, 1'b0, held_req);
  endtask

  task automatic swap_csr(csr_addr_t addr, xlen_t src);
    tick(1'b1, addr, src, 1'b0, held_req);
    idle(1);  // access lands here, old value checked.
  endtask

  task automatic raise_exception(trap_req_t rq);
    tick(1'b0, '0, '0, 1'b0, rq);
    idle(1);
  endtask

  task automatic wait_trap(int limit);
    int n;
    n = 0;
    while (trap_taken !== 1'b1) begin
      if (n == limit) begin
        $display("trap_taken did not rise within %0d cycles", limit);
        stop_on_error();
      end
      idle(1);
      n++;
    end
  endtask

  // ======================================================================
  // test sequence
  // ======================================================================

  initial begin
    logic [31:0] c;
    xlen_t       first;
    int          gap;
    int          idx;
    trap_req_t   rq;
    trap_req_t   exc_list [4];
    seed       = 32'h8ea3;
    n_errors   = 0;
    held_req   = '0;
    reset      = 1'b1;
    csr_instr  = 1'b0;
    csr_addr   = '0;
    csr_src    = '0;
    mret_instr = 1'b0;
    trap_req   = '0;
    pc         = '0;
    addr_list  = '{CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, CSR_MIP,
                   CSR_CYCLE, CSR_CYCLEH, CSR_MTIMECMP, CSR_MTIMECMPH, 12'h123, 12'hfff};
    exc_list   = '{6'b111100, 6'b111000, 6'b110000, 6'b010000};  // 3, 5, 2, 11.
    reset_model();
    repeat (10) @(posedge clock);
    reset <= 1'b0;

    swap_csr(CSR_MTVEC, 32'h0000_1000);
    swap_csr(CSR_MTVEC, 32'h0000_2040);
    swap_csr(CSR_MIE, 32'h0000_0888);
    swap_csr(CSR_MIE, '0);
    swap_csr(CSR_MSTATUS, 32'h0000_0080);
    swap_csr(CSR_MSTATUS, '0);
    swap_csr(12'h123, 32'hdead_beef);
    swap_csr(12'h123, '0);

    swap_csr(CSR_CYCLE, lcg_next());  // read-only, write dropped.
    first = csr_rdata;
    gap   = 1 + int'(lcg_next() >> 28);
    idle(gap);
    swap_csr(CSR_CYCLE, lcg_next());
    check_word("cycle delta", csr_rdata - first, xlen_t'(gap + 2));
    swap_csr(CSR_CYCLE, '0);

    foreach (exc_list[i]) begin
      raise_exception(exc_list[i]);
      swap_csr(CSR_MCAUSE, '0);
    end
    swap_csr(CSR_MSTATUS, 32'h0000_0008);
    raise_exception(exc_list[0]);
    swap_csr(CSR_MSTATUS, 32'h0000_0080);  // reads 0x80, MIE moved to MPIE.
    tick(1'b0, '0, '0, 1'b1, held_req);
    idle(1);
    swap_csr(CSR_MSTATUS, '0);
    tick(1'b1, CSR_MTVEC, 32'hffff_ff00, 1'b0, exc_list[3]);  // dropped by the trap.
    idle(1);
    swap_csr(CSR_MTVEC, 32'h0000_2040);

    swap_csr(CSR_MTIMECMPH, '0);
    swap_csr(CSR_MTIMECMP, m_cycle[31:0] + 32'd20);
    swap_csr(CSR_MSTATUS, 32'h0000_0008);
    idle(30);  // timer pending, MTIE still clear.
    swap_csr(CSR_MIE, 32'h0000_0080);
    wait_trap(50);
    swap_csr(CSR_MCAUSE, '0);

    held_req.soft_int = 1'b1;
    held_req.ext_int  = 1'b1;
    swap_csr(CSR_MIE, 32'h0000_0888);
    for (idx = 0; idx < 3; idx++) begin
      swap_csr(CSR_MSTATUS, 32'h0000_0008);
      wait_trap(10);
      swap_csr(CSR_MCAUSE, '0);
      held_req.ext_int  = 1'b0;
      held_req.soft_int = (idx == 0);
    end
    held_req = '0;

    repeat (1500) begin
      c  = lcg_next();
      rq = '0;
      if (c[31:28] == 4'h0) begin
        rq.break_point   = c[16];
        rq.load_access   = c[17];
        rq.illegal_instr = c[18];
        rq.env_call      = c[19];
      end
      rq.soft_int = c[24] & c[25];
      rq.ext_int  = c[26] & c[27];
      idx = int'((lcg_next() >> 16) % 32'd12);
      tick(c[22] | c[23], addr_list[idx], lcg_next(), c[20] & c[21], rq);
    end

    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
